/* source/tower_pkg.sv */
`default_nettype none

package tower_pkg;

	// screen geometry, 160x120 with coord = {x, y}
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;
	localparam int X_W = 8;  // 0..159
	localparam int Y_W = 7;  // 0..119

	typedef logic [X_W+Y_W-1:0] coord_t;  // x in [14:7], y in [6:0]
	typedef logic [8:0] colour_t;         // rrr ggg bbb

	// tile grid
	localparam int GRID_W = 20;  // tiles across
	localparam int GRID_H = 15;  // tiles down

	// map memory, addr = y*160 + x
	localparam int MAP_ADDR_W = 15;
	localparam int MAP_DEPTH = SCREEN_W * SCREEN_H;  // 19200 entries

	// palette
	localparam colour_t BG_COLOUR = 9'b000_100_000;      // dark green field
	localparam colour_t CURSOR_COLOUR = 9'b111_111_000;  // yellow
	localparam colour_t TOWER_COLOUR = 9'b000_000_111;   // blue

	// player command, one pending at a time
	typedef enum logic [1:0] {
		CMD_NONE = 2'd0,
		CMD_DOWN = 2'd1,
		CMD_RIGHT = 2'd2,
		CMD_DRAW = 2'd3
	} cmd_e;

endpackage

`default_nettype wire

/* source/tower_cmd_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module tower_cmd_capture (
	input logic clk,
	input logic rst,
	input logic go_down,      // one-cycle request pulses
	input logic go_right,
	input logic go_draw,
	input logic enable_draw,  // level, gates all requests
	input logic cmd_take,     // control has accepted the pending command
	output tower_pkg::cmd_e cmd,
	output logic cmd_valid
);

	tower_pkg::cmd_e req_cmd;  // winner among this cycle's pulses
	logic req_any;

	assign req_any = go_down | go_right | go_draw;

	// draw beats right beats down
	always_comb begin
		if (go_draw) begin
			req_cmd = tower_pkg::CMD_DRAW;
		end else if (go_right) begin
			req_cmd = tower_pkg::CMD_RIGHT;
		end else if (go_down) begin
			req_cmd = tower_pkg::CMD_DOWN;
		end else begin
			req_cmd = tower_pkg::CMD_NONE;
		end
	end

	// single entry holding register
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_valid <= 1'b0;
			cmd <= tower_pkg::CMD_NONE;
		end else if (cmd_take) begin
			cmd_valid <= 1'b0;  // empty again next cycle
			cmd <= tower_pkg::CMD_NONE;
		end else if (!cmd_valid && enable_draw && req_any) begin
			cmd_valid <= 1'b1;
			cmd <= req_cmd;
		end
		// anything else is dropped while busy or disabled
	end

	// control may only take what is actually pending
	take_needs_valid: assert property (
		@(posedge clk) disable iff (rst) cmd_take |-> cmd_valid
	);

endmodule

`default_nettype wire

/* source/control_towerplacer.sv */
`timescale 1ns/100ps
`default_nettype none

module control_towerplacer (
	input logic clk,
	input logic rst,
	input tower_pkg::cmd_e cmd,
	input logic cmd_valid,
	input logic square_done,  // last pixel of the scan issued
	input logic valid,        // tile free, one cycle after check
	input logic tower_done,   // tower finished or rejected
	input logic queue_room,
	output logic cmd_take,
	output logic top_left,
	output logic erase_square,
	output logic move_right,
	output logic move_down,
	output logic check_valid,
	output logic draw_square,
	output logic draw_tower
);

	typedef enum logic [3:0] {
		S_TOP,         // home the cursor after reset
		S_DRAW,        // cursor scan
		S_IDLE,        // wait for a command
		S_ERASE,       // restore old tile from map
		S_MOVE,        // step one tile
		S_CHECK,       // read tile top-left from map
		S_CHECK_WAIT,  // map data arrives here
		S_TOWER,       // tower scan, also written to map
		S_TOWER_WAIT   // wait for tower_done after the last push
	} state_e;

	state_e state, state_next;
	logic dir_right;  // direction of the move in progress

	assign cmd_take = (state == S_IDLE) && cmd_valid && queue_room;

	always_comb begin
		state_next = state;
		case (state)
			S_TOP: state_next = S_DRAW;
			S_DRAW: if (square_done) state_next = S_IDLE;
			S_IDLE: begin
				if (cmd_take) begin
					case (cmd)
						tower_pkg::CMD_DOWN,
						tower_pkg::CMD_RIGHT: state_next = S_ERASE;
						tower_pkg::CMD_DRAW: state_next = S_CHECK;
						default: state_next = S_IDLE;  // none, just consumed
					endcase
				end
			end
			S_ERASE: if (square_done) state_next = S_MOVE;
			S_MOVE: state_next = S_DRAW;
			S_CHECK: state_next = S_CHECK_WAIT;
			S_CHECK_WAIT: state_next = valid ? S_TOWER : S_IDLE;  // occupied tile is rejected
			S_TOWER: if (square_done) state_next = S_TOWER_WAIT;
			S_TOWER_WAIT: if (tower_done) state_next = S_IDLE;
			default: state_next = S_TOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_TOP;
			dir_right <= 1'b0;
		end else begin
			state <= state_next;
			if (cmd_take) dir_right <= (cmd == tower_pkg::CMD_RIGHT);  // latch with take
		end
	end

	// phase strobes straight from state
	assign top_left = (state == S_TOP);
	assign draw_square = (state == S_DRAW);
	assign erase_square = (state == S_ERASE);
	assign move_right = (state == S_MOVE) && dir_right;
	assign move_down = (state == S_MOVE) && !dir_right;
	assign check_valid = (state == S_CHECK);
	assign draw_tower = (state == S_TOWER);

	// datapath relies on at most one phase at a time
	phase_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0({top_left, erase_square, move_right, move_down,
			check_valid, draw_square, draw_tower})
	);

endmodule

`default_nettype wire

/* source/datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module datapath #(
	parameter int TILE_SIZE = 8
) (
	input logic clk,
	input logic rst,
	input logic top_left,
	input logic erase_square,
	input logic move_right,
	input logic move_down,
	input logic check_valid,
	input logic draw_square,
	input logic draw_tower,
	input logic queue_room,
	input tower_pkg::colour_t map_colour,  // one cycle after map_rd_addr
	output logic [tower_pkg::MAP_ADDR_W-1:0] map_rd_addr,
	output logic [tower_pkg::MAP_ADDR_W-1:0] map_wr_addr,
	output logic map_wr,
	output logic pix_push,
	output tower_pkg::coord_t pix_coord,
	output tower_pkg::colour_t pix_colour,
	output logic square_done,
	output logic valid,
	output logic tower_done
);

	localparam int TW = $clog2(TILE_SIZE);  // bits per in-tile axis
	localparam int GXW = $clog2(tower_pkg::GRID_W);
	localparam int GYW = $clog2(tower_pkg::GRID_H);
	localparam int XW = tower_pkg::X_W;
	localparam int YW = tower_pkg::Y_W;
	localparam int AW = tower_pkg::MAP_ADDR_W;

	logic [GXW-1:0] tile_x;
	logic [GYW-1:0] tile_y;
	logic [2*TW-1:0] scan_cnt;  // {row, col} within the tile
	logic scan_go;              // a pixel is issued this cycle
	logic [XW-1:0] x_pix;
	logic [YW-1:0] y_pix;
	logic [AW-1:0] pix_addr;

	// issue stage, pushed one cycle later
	logic push_q, erase_q, tower_q, tower_last_q, check_q;
	tower_pkg::coord_t coord_q;
	tower_pkg::colour_t colour_q;
	logic [AW-1:0] addr_q;

	assign scan_go = (erase_square | draw_square | draw_tower) && queue_room;
	assign square_done = scan_go && (scan_cnt == '1);

	assign x_pix = XW'(int'(tile_x) * TILE_SIZE + int'(scan_cnt[TW-1:0]));
	assign y_pix = YW'(int'(tile_y) * TILE_SIZE + int'(scan_cnt[2*TW-1:TW]));
	assign pix_addr = AW'(int'(y_pix) * tower_pkg::SCREEN_W + int'(x_pix));
	assign map_rd_addr = pix_addr;  // counter is 0 outside scans, so top-left for check

	// cursor tile, wraps at grid edge
	always_ff @(posedge clk) begin
		if (rst || top_left) begin
			tile_x <= '0;
			tile_y <= '0;
		end else if (move_right) begin
			tile_x <= (int'(tile_x) == tower_pkg::GRID_W - 1) ? '0 : tile_x + 1'b1;
		end else if (move_down) begin
			tile_y <= (int'(tile_y) == tower_pkg::GRID_H - 1) ? '0 : tile_y + 1'b1;
		end
	end

	// raster scan, rolls back to 0 on the last pixel
	always_ff @(posedge clk) begin
		if (rst || top_left) scan_cnt <= '0;
		else if (scan_go) scan_cnt <= scan_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			push_q <= 1'b0;
			tower_q <= 1'b0;
			tower_last_q <= 1'b0;
			check_q <= 1'b0;
		end else begin
			push_q <= scan_go;
			tower_q <= scan_go && draw_tower;
			tower_last_q <= square_done && draw_tower;
			check_q <= check_valid;
		end
	end

	// pixel payload
	always_ff @(posedge clk) begin
		erase_q <= erase_square;
		coord_q <= {x_pix, y_pix};
		addr_q <= pix_addr;
		colour_q <= draw_tower ? tower_pkg::TOWER_COLOUR : tower_pkg::CURSOR_COLOUR;
	end

	assign pix_push = push_q;
	assign pix_coord = coord_q;
	assign pix_colour = erase_q ? map_colour : colour_q;  // erase restores from map

	// tower goes into the map alongside its push
	assign map_wr = push_q && tower_q;
	assign map_wr_addr = addr_q;

	// top-left pixel decides whether the tile already holds a tower
	assign valid = check_q && (map_colour != tower_pkg::TOWER_COLOUR);
	assign tower_done = tower_last_q || (check_q && (map_colour == tower_pkg::TOWER_COLOUR));

endmodule

`default_nettype wire

/* source/map_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module map_memory (
	input logic clk,
	input logic [tower_pkg::MAP_ADDR_W-1:0] rd_addr,
	output tower_pkg::colour_t rd_colour,
	input logic wr,
	input logic [tower_pkg::MAP_ADDR_W-1:0] wr_addr,
	input tower_pkg::colour_t wr_colour
);

	// one colour per screen pixel
	tower_pkg::colour_t mem [tower_pkg::MAP_DEPTH];

	// whole field starts as background
	initial begin
		for (int i = 0; i < tower_pkg::MAP_DEPTH; i++) begin
			mem[i] = tower_pkg::BG_COLOUR;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_addr] <= wr_colour;  // tower pixels only
		end
	end

	// registered read, data valid the next cycle
	always_ff @(posedge clk) begin
		rd_colour <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* source/pixel_credit_out.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_credit_out #(
	parameter int QUEUE_DEPTH = 4,
	parameter int LINK_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic pix_push,
	input tower_pkg::coord_t pix_coord,
	input tower_pkg::colour_t pix_colour,
	output logic queue_room,  // two or more slots free
	input logic vga_credit,   // sink freed one pixel
	output logic vga_WriteEn,
	output tower_pkg::coord_t vga_coords,
	output tower_pkg::colour_t vga_colour
);

	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam int KW = $clog2(LINK_CREDITS + 1);

	tower_pkg::coord_t q_coord [QUEUE_DEPTH];
	tower_pkg::colour_t q_colour [QUEUE_DEPTH];
	logic [PW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;    // entries held
	logic [KW-1:0] credits;  // pixels the sink can still take
	logic pop;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		return (int'(p) == QUEUE_DEPTH - 1) ? '0 : p + 1'b1;
	endfunction

	assign pop = (count != '0) && (credits != '0);  // send head when sink has space
	assign vga_WriteEn = pop;
	assign vga_coords = q_coord[rd_ptr];
	assign vga_colour = q_colour[rd_ptr];
	assign queue_room = (int'(count) + 2 <= QUEUE_DEPTH);  // covers a push already in flight

	always_ff @(posedge clk) begin
		if (pix_push) begin
			q_coord[wr_ptr] <= pix_coord;
			q_colour[wr_ptr] <= pix_colour;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= KW'(LINK_CREDITS);  // sink starts empty
		end else begin
			if (pix_push) wr_ptr <= ptr_next(wr_ptr);
			if (pop) rd_ptr <= ptr_next(rd_ptr);
			case ({pix_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({pop, vga_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;  // both or neither
			endcase
		end
	end

	// datapath must honour queue_room
	no_push_when_full: assert property (
		@(posedge clk) disable iff (rst) pix_push |-> (int'(count) < QUEUE_DEPTH)
	);

	// sink never returns more credits than it was given
	credit_bound: assert property (
		@(posedge clk) disable iff (rst) int'(credits) <= LINK_CREDITS
	);

endmodule

`default_nettype wire

/* source/tower.sv */
`timescale 1ns/100ps
`default_nettype none

module tower #(
	parameter int TILE_SIZE = 8,
	parameter int QUEUE_DEPTH = 4,
	parameter int LINK_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic go_down,
	input logic go_right,
	input logic go_draw,
	input logic enable_draw,
	input logic vga_credit,
	output logic vga_WriteEn,
	output tower_pkg::coord_t vga_coords,
	output tower_pkg::colour_t vga_colour,
	output logic tower_done_out,
	output logic writeToMap,
	output logic [tower_pkg::MAP_ADDR_W-1:0] erase_mem_address
);

	// input side to control
	tower_pkg::cmd_e cmd;
	logic cmd_valid, cmd_take;

	// phase strobes and feedback
	logic top_left, erase_square, move_right, move_down;
	logic check_valid, draw_square, draw_tower;
	logic square_done, valid, tower_done;

	// map and pixel paths
	logic [tower_pkg::MAP_ADDR_W-1:0] map_rd_addr, map_wr_addr;
	logic map_wr;
	tower_pkg::colour_t map_colour;
	logic pix_push, queue_room;
	tower_pkg::coord_t pix_coord;
	tower_pkg::colour_t pix_colour;

	assign tower_done_out = tower_done;
	assign writeToMap = map_wr;
	assign erase_mem_address = map_rd_addr;

	tower_cmd_capture i0 (
		.clk(clk), .rst(rst),
		.go_down(go_down), .go_right(go_right), .go_draw(go_draw),
		.enable_draw(enable_draw), .cmd_take(cmd_take),
		.cmd(cmd), .cmd_valid(cmd_valid)
	);

	control_towerplacer c0 (
		.clk(clk), .rst(rst),
		.cmd(cmd), .cmd_valid(cmd_valid),
		.square_done(square_done), .valid(valid), .tower_done(tower_done),
		.queue_room(queue_room), .cmd_take(cmd_take),
		.top_left(top_left), .erase_square(erase_square),
		.move_right(move_right), .move_down(move_down),
		.check_valid(check_valid), .draw_square(draw_square), .draw_tower(draw_tower)
	);

	datapath #(.TILE_SIZE(TILE_SIZE)) d0 (
		.clk(clk), .rst(rst),
		.top_left(top_left), .erase_square(erase_square),
		.move_right(move_right), .move_down(move_down),
		.check_valid(check_valid), .draw_square(draw_square), .draw_tower(draw_tower),
		.queue_room(queue_room), .map_colour(map_colour),
		.map_rd_addr(map_rd_addr), .map_wr_addr(map_wr_addr), .map_wr(map_wr),
		.pix_push(pix_push), .pix_coord(pix_coord), .pix_colour(pix_colour),
		.square_done(square_done), .valid(valid), .tower_done(tower_done)
	);

	map_memory m0 (
		.clk(clk),
		.rd_addr(map_rd_addr), .rd_colour(map_colour),
		.wr(map_wr), .wr_addr(map_wr_addr), .wr_colour(tower_pkg::TOWER_COLOUR)
	);

	pixel_credit_out #(.QUEUE_DEPTH(QUEUE_DEPTH), .LINK_CREDITS(LINK_CREDITS)) o0 (
		.clk(clk), .rst(rst),
		.pix_push(pix_push), .pix_coord(pix_coord), .pix_colour(pix_colour),
		.queue_room(queue_room), .vga_credit(vga_credit),
		.vga_WriteEn(vga_WriteEn), .vga_coords(vga_coords), .vga_colour(vga_colour)
	);

endmodule

`default_nettype wire

/* dv/tower_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module tower_tb;

	localparam int TILE = 8;         // pixels per tile edge
	localparam int QDEPTH = 4;
	localparam int CREDITS = 2;      // sink buffer size
	localparam int NROWS = 14;
	localparam int SETTLE = 16;      // idle cycles that would expose stray pixels
	localparam int IGNORE_WIN = 200;

	typedef enum int {R_MOVED, R_PLACED, R_REJECTED, R_IGNORED} result_e;

	typedef struct packed {
		tower_pkg::cmd_e cmd;
		logic en;      // enable_draw level for the row
		int reps;      // times the command is issued
		int tx;        // tile expected afterwards
		int ty;
		result_e res;
	} row_t;

	logic clk = 1'b0;
	logic rst, go_down, go_right, go_draw, enable_draw;
	logic vga_credit = 1'b0;
	logic vga_WriteEn, tower_done_out, writeToMap;
	tower_pkg::coord_t vga_coords;
	tower_pkg::colour_t vga_colour;
	logic [tower_pkg::MAP_ADDR_W-1:0] erase_mem_address;

	row_t rows [NROWS];
	tower_pkg::colour_t ref_map [tower_pkg::MAP_DEPTH];  // predicts erase colours
	tower_pkg::coord_t got_coord [$];    // everything the sink received
	tower_pkg::colour_t got_colour [$];
	tower_pkg::coord_t exp_coord [$];    // stream expected for one command
	tower_pkg::colour_t exp_colour [$];
	int got_wr_addr [$];                 // map writes seen, in order
	int exp_wr_addr [$];                 // tower writes expected for one command
	logic [tower_pkg::MAP_ADDR_W-1:0] prev_rd_addr = '0;  // address one cycle back
	int credit_due [$];                  // cycle at which each credit goes back
	int cycle = 0;
	int limit = 0;
	int outstanding = 0;                 // pixels sent but not yet credited
	int done_cnt = 0;
	int errors = 0;
	int tests_failed = 0;
	logic [31:0] lfsr = 32'h18f6852f;
	int cur_x = 0;                       // cursor tile per the model
	int cur_y = 0;

	tower #(.TILE_SIZE(TILE), .QUEUE_DEPTH(QDEPTH), .LINK_CREDITS(CREDITS)) UUT (
		.clk(clk), .rst(rst),
		.go_down(go_down), .go_right(go_right), .go_draw(go_draw),
		.enable_draw(enable_draw), .vga_credit(vga_credit),
		.vga_WriteEn(vga_WriteEn), .vga_coords(vga_coords), .vga_colour(vga_colour),
		.tower_done_out(tower_done_out), .writeToMap(writeToMap),
		.erase_mem_address(erase_mem_address)
	);

	initial begin
		forever #2 clk = ~clk;  // 4 ns period
	end

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic row_t table_row(input tower_pkg::cmd_e c, input logic en, input int reps,
			input int tx, input int ty, input result_e res);
		row_t r;
		r.cmd = c;
		r.en = en;
		r.reps = reps;
		r.tx = tx;
		r.ty = ty;
		r.res = res;
		return r;
	endfunction

	function automatic string cmd_name(input tower_pkg::cmd_e c);
		case (c)
			tower_pkg::CMD_DOWN: return "down";
			tower_pkg::CMD_RIGHT: return "right";
			tower_pkg::CMD_DRAW: return "draw";
			default: return "none";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// sink model, credit return, event counters and the watchdog
	always @(posedge clk) begin
		logic [1:0] delay;
		int b;
		cycle++;
		if (cycle >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end else if (rst) begin
			outstanding = 0;
			vga_credit <= 1'b0;
		end else begin
			if (vga_WriteEn) begin
				if (outstanding >= CREDITS) begin
					errors++;
					$display("vga_WriteEn raised with %0d pixels already outstanding",
						outstanding);
				end
				got_coord.push_back(vga_coords);
				got_colour.push_back(vga_colour);
				delay = '0;
				for (b = 0; b < 2; b++) begin  // one step per bit
					lfsr = lfsr_next(lfsr);
					delay = {delay[0], lfsr[0]};
				end
				credit_due.push_back(cycle + 1 + int'(delay));  // 0..3 cycles late
			end
			if (tower_done_out) done_cnt++;
			// the push trails its address by a cycle, and so does the map write
			if (writeToMap) got_wr_addr.push_back(int'(prev_rd_addr));
			prev_rd_addr = erase_mem_address;
			outstanding = outstanding + int'(vga_WriteEn) - int'(vga_credit);
			if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
				vga_credit <= 1'b1;  // at most one credit per cycle
				void'(credit_due.pop_front());
			end else begin
				vga_credit <= 1'b0;
			end
		end
	end

	// one tile in raster order, colour from the map or a fixed fill
	task automatic add_square(input int tx, input int ty, input logic from_map,
			input tower_pkg::colour_t fill);
		int x, y, r, c;
		for (r = 0; r < TILE; r++) begin
			for (c = 0; c < TILE; c++) begin
				x = tx * TILE + c;
				y = ty * TILE + r;
				exp_coord.push_back({x[7:0], y[6:0]});
				exp_colour.push_back(from_map ? ref_map[y * tower_pkg::SCREEN_W + x] : fill);
			end
		end
	endtask

	task automatic mark_tower(input int tx, input int ty);
		int r, c, a;
		for (r = 0; r < TILE; r++) begin
			for (c = 0; c < TILE; c++) begin
				a = (ty * TILE + r) * tower_pkg::SCREEN_W + tx * TILE + c;
				ref_map[a] = tower_pkg::TOWER_COLOUR;
				exp_wr_addr.push_back(a);  // same raster order as the pixels
			end
		end
	endtask

	task automatic pulse_cmd(input tower_pkg::cmd_e c, input logic en);
		@(posedge clk);
		enable_draw <= en;
		go_down <= (c == tower_pkg::CMD_DOWN);
		go_right <= (c == tower_pkg::CMD_RIGHT);
		go_draw <= (c == tower_pkg::CMD_DRAW);
		@(posedge clk);
		go_down <= 1'b0;  // single cycle request
		go_right <= 1'b0;
		go_draw <= 1'b0;
	endtask

	// wait for the end marker, then compare the whole stream
	task automatic wait_and_compare(input int pix0, input int done0, input int wr0,
			input int exp_done, input logic idle_window);
		int n, nw, i;
		if (idle_window) begin
			repeat (IGNORE_WIN) @(negedge clk);
		end else begin
			while (got_coord.size() - pix0 < exp_coord.size() || done_cnt - done0 < exp_done)
				@(negedge clk);
		end
		repeat (SETTLE) @(negedge clk);
		n = got_coord.size() - pix0;
		nw = got_wr_addr.size() - wr0;
		check_value("pixel_count", n, exp_coord.size());
		check_value("tower_done_out_count", done_cnt - done0, exp_done);
		check_value("writeToMap_count", nw, exp_wr_addr.size());
		for (i = 0; i < exp_coord.size() && i < n; i++) begin
			if (got_coord[pix0 + i] !== exp_coord[i] ||
					got_colour[pix0 + i] !== exp_colour[i]) begin
				check_value("vga_coords", got_coord[pix0 + i], exp_coord[i]);
				check_value("vga_colour", got_colour[pix0 + i], exp_colour[i]);
				break;  // one report per stream is enough
			end
		end
		for (i = 0; i < exp_wr_addr.size() && i < nw; i++) begin
			if (got_wr_addr[wr0 + i] != exp_wr_addr[i]) begin
				check_value("writeToMap_addr", got_wr_addr[wr0 + i], exp_wr_addr[i]);
				break;
			end
		end
	endtask

	task automatic run_row(input int idx);
		row_t row;
		result_e predicted;
		int k, nx, ny, pix0, done0, wr0, err0;
		row = rows[idx];
		err0 = errors;
		for (k = 0; k < row.reps; k++) begin
			exp_coord.delete();
			exp_colour.delete();
			exp_wr_addr.delete();
			nx = cur_x;
			ny = cur_y;
			if (!row.en) begin
				predicted = R_IGNORED;
			end else if (row.cmd == tower_pkg::CMD_DRAW) begin
				// top-left pixel decides occupancy
				predicted = (ref_map[cur_y * TILE * tower_pkg::SCREEN_W + cur_x * TILE] ==
					tower_pkg::TOWER_COLOUR) ? R_REJECTED : R_PLACED;
			end else begin
				predicted = R_MOVED;
				if (row.cmd == tower_pkg::CMD_RIGHT) begin
					nx = (cur_x == tower_pkg::GRID_W - 1) ? 0 : cur_x + 1;
				end else begin
					ny = (cur_y == tower_pkg::GRID_H - 1) ? 0 : cur_y + 1;
				end
			end
			check_value("result", predicted, row.res);
			if (predicted == R_MOVED) begin
				add_square(cur_x, cur_y, 1'b1, tower_pkg::BG_COLOUR);  // erase from map
				add_square(nx, ny, 1'b0, tower_pkg::CURSOR_COLOUR);
			end else if (predicted == R_PLACED) begin
				add_square(cur_x, cur_y, 1'b0, tower_pkg::TOWER_COLOUR);
				mark_tower(cur_x, cur_y);
			end
			@(negedge clk);
			pix0 = got_coord.size();
			done0 = done_cnt;
			wr0 = got_wr_addr.size();
			pulse_cmd(row.cmd, row.en);
			wait_and_compare(pix0, done0, wr0,
				(predicted == R_PLACED || predicted == R_REJECTED) ? 1 : 0,
				predicted == R_IGNORED);
			cur_x = nx;
			cur_y = ny;
		end
		check_value("tile_x", cur_x, row.tx);
		check_value("tile_y", cur_y, row.ty);
		if (errors != err0) tests_failed++;
		$display("test %0d: %s x%0d enable %0b, tile (%0d,%0d): %s", idx + 2,
			cmd_name(row.cmd), row.reps, row.en, cur_x, cur_y,
			(errors == err0) ? "pass" : "fail");
	endtask

	initial begin
		int i, total_cmds, ignored_rows, err0;
		rst = 1'b1;
		go_down = 1'b0;
		go_right = 1'b0;
		go_draw = 1'b0;
		enable_draw = 1'b1;
		for (i = 0; i < tower_pkg::MAP_DEPTH; i++) ref_map[i] = tower_pkg::BG_COLOUR;

		rows[0] = table_row(tower_pkg::CMD_RIGHT, 1'b1, 1, 1, 0, R_MOVED);
		rows[1] = table_row(tower_pkg::CMD_DOWN, 1'b1, 1, 1, 1, R_MOVED);
		rows[2] = table_row(tower_pkg::CMD_DRAW, 1'b1, 1, 1, 1, R_PLACED);
		rows[3] = table_row(tower_pkg::CMD_DRAW, 1'b1, 1, 1, 1, R_REJECTED);  // same tile again
		rows[4] = table_row(tower_pkg::CMD_RIGHT, 1'b1, 1, 2, 1, R_MOVED);    // erase keeps tower
		rows[5] = table_row(tower_pkg::CMD_RIGHT, 1'b0, 1, 2, 1, R_IGNORED);
		rows[6] = table_row(tower_pkg::CMD_DRAW, 1'b0, 1, 2, 1, R_IGNORED);
		rows[7] = table_row(tower_pkg::CMD_RIGHT, 1'b1, 17, 19, 1, R_MOVED);  // last column
		rows[8] = table_row(tower_pkg::CMD_RIGHT, 1'b1, 1, 0, 1, R_MOVED);    // column wrap
		rows[9] = table_row(tower_pkg::CMD_DOWN, 1'b1, 13, 0, 14, R_MOVED);   // last row
		rows[10] = table_row(tower_pkg::CMD_DOWN, 1'b1, 1, 0, 0, R_MOVED);    // row wrap
		rows[11] = table_row(tower_pkg::CMD_DRAW, 1'b1, 1, 0, 0, R_PLACED);
		rows[12] = table_row(tower_pkg::CMD_DOWN, 1'b1, 1, 0, 1, R_MOVED);
		rows[13] = table_row(tower_pkg::CMD_DRAW, 1'b1, 1, 0, 1, R_PLACED);

		total_cmds = 1;  // reset cursor draw
		ignored_rows = 0;
		for (i = 0; i < NROWS; i++) begin
			total_cmds += rows[i].reps;
			if (!rows[i].en) ignored_rows++;
		end
		limit = total_cmds * 128 * 5 + ignored_rows * IGNORE_WIN + 2000;

		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// cursor homes at tile (0,0) by itself
		err0 = errors;
		exp_coord.delete();
		exp_colour.delete();
		exp_wr_addr.delete();
		add_square(0, 0, 1'b0, tower_pkg::CURSOR_COLOUR);
		wait_and_compare(0, 0, 0, 0, 1'b0);
		if (errors != err0) tests_failed++;
		$display("test 1: reset cursor at tile (0,0): %s", (errors == err0) ? "pass" : "fail");

		for (i = 0; i < NROWS; i++) run_row(i);

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d pixels",
			NROWS + 1, NROWS + 1 - tests_failed, tests_failed, errors, got_coord.size());
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/tower_pkg.sv
source/tower_cmd_capture.sv
source/control_towerplacer.sv
source/datapath.sv
source/map_memory.sv
source/pixel_credit_out.sv
source/tower.sv
dv/tower_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tower_tb
RTL_TOP    := tower
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
